/* bench/bench_input.txt */
# columns: opcode address data byteenable expected, all hex
# W write, R read, M random sram fill (data = words), C sram check, H hid send, K hid read, I irq levels, A irq lines, V ctrl outputs
V 0 0 0 0
M 02000000 10 f 0
M 02000004 4 3 0
M 02000020 2 c 0
W 02000010 a5a5a5a5 2 0
C 02000000 10 0 0
W 02010000 80001234 f 0
V 0 0 0 0
W 02010004 7fffffff f 0
W 02060000 00000001 f 0
W 02060004 0000beef f 0
W 02060008 00000001 f 0
W 0206000c ffffffff f 0
V 0 0 0 0
R 02010000 0 f 0
R 02060004 0 f 0
R 02030000 0 f 0
R 02040000 0 f 0
R 02050000 0 f 0
R 04000000 0 f 0
I 0 1 0 0
A 0 0 0 5
I 0 3 0 0
A 0 0 0 7
R 02020000 0 f 3
I 0 0 0 0
A 0 0 0 4
W 02020000 1 f 0
R 02020000 0 f 2
W 02020000 2 f 0
R 02020000 0 f 0
A 0 0 0 0
H 0 0 0 0
R 02020000 0 f 4
K 02070000 0 f 0
R 02070000 0 f 0
W 02020000 4 f 0
R 02020000 0 f 0

/* bench/tb_soc_fabric.sv */
`timescale 1ns/1ns

module tb_soc_fabric
  import sys_map_pkg::*;
  import sys_regs_pkg::*;
;

  localparam int clk_period = 8;

  logic                   clk;
  logic                   reset_n;
  logic [addr_w-1:0]      address;
  logic                   read;
  logic                   write;
  logic [data_w-1:0]      writedata;
  logic [be_w-1:0]        byteenable;
  logic [data_w-1:0]      readdata;
  logic                   waitrequest;
  logic                   timer_irq;
  logic                   uart_irq;
  logic                   timer_ack;
  logic                   uart_ack;
  logic                   irq_req;
  logic                   hid_dat;
  logic                   hid_clk;
  logic                   hid_str;
  logic                   flush_cache;
  logic [page_w-1:0]      flush_page;
  logic [vga_mode_w-1:0]  vga_mode;
  logic [line_base_w-1:0] line_base;
  logic                   block_vga;

  int          errors;
  int          n_ops;      // operations loaded from the input file
  logic [31:0] lcg_state;  // random stream for sram data and hid bits
  logic [31:0] hid_word;   // word expected from the last hid send

  logic [7:0]  op_q[$];    // one entry per input line
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0]  be_q[$];
  logic [31:0] exp_q[$];

  logic [31:0]            shadow [sram_words];  // expected sram contents
  logic                   m_flush;              // expected ctrl_regs outputs
  logic [page_w-1:0]      m_page;
  logic [vga_mode_w-1:0]  m_mode;
  logic [line_base_w-1:0] m_base;
  logic                   m_block;

  soc_fabric dut0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .timer_irq   (timer_irq),
    .uart_irq    (uart_irq),
    .timer_ack   (timer_ack),
    .uart_ack    (uart_ack),
    .irq_req     (irq_req),
    .hid_dat     (hid_dat),
    .hid_clk     (hid_clk),
    .hid_str     (hid_str),
    .flush_cache (flush_cache),
    .flush_page  (flush_page),
    .vga_mode    (vga_mode),
    .line_base   (line_base),
    .block_vga   (block_vga)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;  // classic lcg constants
  endfunction

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive just after the edge
  endtask

  // one master transfer held until waitrequest drops
  task automatic bus_xfer(input logic wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] be, output logic [31:0] rd);
    int waits;
    int exp_waits;
    waits     = 0;
    exp_waits = (!wr && a[31:16] == region_sram) ? 1 : 0;  // only sram reads stall
    address    = a;
    writedata  = d;
    byteenable = be;
    write      = wr;
    read       = !wr;
    @(negedge clk);  // sample mid cycle
    while (waitrequest) begin
      waits++;
      @(negedge clk);
    end
    rd = readdata;
    @(posedge clk);  // transfer completes here
    #1;
    read  = 1'b0;
    write = 1'b0;
    assert (waits == exp_waits) else begin
      errors++;
      $display("[ERROR] %0t %0d wait states at %h, expected %0d", $time, waits, a, exp_waits);
    end
  endtask

  task automatic compare_word(input logic [31:0] a, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %0t read %h returned %h, expected %h", $time, a, got, exp);
    end
  endtask

  // reference model of every write the master makes
  task automatic model_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
    logic [13:0] idx;
    idx = a[15:2];
    if (a[31:16] == region_sram) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (be[lane]) shadow[a[10:2]][lane*8 +: 8] = d[lane*8 +: 8];  // merge enabled lanes
      end
    end else if (a[31:16] == region_cache && idx == 14'd0) begin
      m_flush = d[31];
      m_page  = d[14:0];
    end else if (a[31:16] == region_vga) begin
      case (idx)
        14'd0:   m_mode  = d[1:0];
        14'd1:   m_base  = d[15:0];
        14'd2:   m_block = d[0];
        default: ;  // ignored index
      endcase
    end
  endtask

  task automatic sram_fill(input logic [31:0] a, input int count, input logic [3:0] be);
    logic [31:0] rd;
    for (int i = 0; i < count; i++) begin
      lcg_state = lcg_next(lcg_state);
      bus_xfer(1'b1, a + 32'(i*4), lcg_state, be, rd);
      model_write(a + 32'(i*4), lcg_state, be);
    end
  endtask

  task automatic sram_check(input logic [31:0] a, input int count);
    logic [31:0] rd;
    logic [31:0] addr_i;
    for (int i = 0; i < count; i++) begin
      addr_i = a + 32'(i*4);
      bus_xfer(1'b0, addr_i, 32'd0, 4'hf, rd);  // back-to-back reads
      compare_word(addr_i, rd, shadow[addr_i[10:2]]);
    end
  endtask

  // 32 random bits with the last one sent landing in bit 31
  task automatic hid_send();
    logic [31:0] word;
    for (int i = 0; i < 32; i++) begin
      lcg_state = lcg_next(lcg_state);
      hid_dat   = lcg_state[16];
      word[i]   = lcg_state[16];
      hid_clk   = 1'b0;
      step(3);
      hid_clk = 1'b1;  // slow edge seen after the synchronizer
      step(3);
    end
    hid_clk = 1'b0;
    hid_str = 1'b1;
    step(3);
    hid_str = 1'b0;
    step(3);
    hid_word = word;
  endtask

  // bounded wait for {irq_req, uart_ack, timer_ack}
  task automatic wait_irq_lines(input logic [2:0] exp);
    int n;
    n = 0;
    @(negedge clk);
    while ({irq_req, uart_ack, timer_ack} != exp && n < 10) begin
      n++;
      @(negedge clk);
    end
    assert ({irq_req, uart_ack, timer_ack} == exp) else begin
      errors++;
      $display("[ERROR] %0t irq lines %b, expected %b", $time,
               {irq_req, uart_ack, timer_ack}, exp);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_ctrl();
    @(negedge clk);
    assert (flush_cache == m_flush && flush_page == m_page && vga_mode == m_mode &&
            line_base == m_base && block_vga == m_block) else begin
      errors++;
      $display("[ERROR] %0t ctrl outputs %b %h %h %h %b, expected %b %h %h %h %b", $time,
               flush_cache, flush_page, vga_mode, line_base, block_vga,
               m_flush, m_page, m_mode, m_base, m_block);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] d,
                        input logic [3:0] be, input logic [31:0] e);
    logic [31:0] rd;
    case (op)
      "W": begin
        bus_xfer(1'b1, a, d, be, rd);
        model_write(a, d, be);
      end
      "R": begin
        bus_xfer(1'b0, a, 32'd0, be, rd);
        compare_word(a, rd, e);
      end
      "M": sram_fill(a, int'(d), be);
      "C": sram_check(a, int'(d));
      "H": hid_send();
      "K": begin
        bus_xfer(1'b0, a, 32'd0, be, rd);
        compare_word(a, rd, hid_word);
      end
      "I": begin
        timer_irq = d[0];  // level bit 0 drives timer and bit 1 uart
        uart_irq  = d[1];
      end
      "A": wait_irq_lines(e[2:0]);
      "V": check_ctrl();
      default: begin
        errors++;
        $display("unknown opcode %s in the stimulus file", op);
      end
    endcase
  endtask

  initial begin
    int          fd;
    int          cnt;
    string       line;
    logic [7:0]  op_c;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  be;
    logic [31:0] e;
    errors     = 0;
    n_ops      = 0;
    lcg_state  = 32'd65;  // seed
    hid_word   = '0;
    reset_n    = 1'b0;
    address    = '0;
    read       = 1'b0;
    write      = 1'b0;
    writedata  = '0;
    byteenable = '0;
    timer_irq  = 1'b0;
    uart_irq   = 1'b0;
    hid_dat    = 1'b0;
    hid_clk    = 1'b0;
    hid_str    = 1'b0;
    m_flush    = 1'b0;
    m_page     = '0;
    m_mode     = 2'd3;  // vga mode out of reset
    m_base     = '0;
    m_block    = 1'b0;
    fd = $fopen("bench/bench_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file bench/bench_input.txt");
      $display("Test FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments and blanks
          cnt = $sscanf(line, "%s %h %h %h %h", op_c, a, d, be, e);
          if (cnt == 5) begin
            op_q.push_back(op_c);
            addr_q.push_back(a);
            data_q.push_back(d);
            be_q.push_back(be);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
      n_ops = op_q.size();  // arms the watchdog
      step(2);
      reset_n = 1'b1;
      assert (!waitrequest && !irq_req && !timer_ack && !uart_ack) else begin
        errors++;
        $display("[ERROR] %0t handshake or irq lines high after reset", $time);
      end
      for (int k = 0; k < n_ops; k++) begin
        run_op(op_q[k], addr_q[k], data_q[k], be_q[k], exp_q[k]);
      end
      $display("run complete, %0d errors", errors);
      if (errors == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

  // budget of 200 cycles per operation
  initial begin
    wait (n_ops > 0);
    #(n_ops * 200 * clk_period);
    $display("timeout: the operations did not finish within the watchdog limit");
    $display("Test FAILED");
    $finish;
  end

endmodule

/* logic/bus_decode.sv */
`timescale 1ns/1ns

module bus_decode
  import sys_map_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  input  logic [addr_w-1:0]  address,
  input  logic               read,
  input  logic               write,
  input  logic [data_w-1:0]  sram_readdata,
  input  logic               sram_waitrequest,
  input  logic [data_w-1:0]  irq_readdata,
  input  logic [data_w-1:0]  hid_readdata,
  output logic [index_w-1:0] word_index,
  output logic               sram_read,
  output logic               sram_write,
  output logic               irq_write,
  output logic               cache_write,
  output logic               vga_write,
  output logic               hid_read,
  output logic [data_w-1:0]  readdata,
  output logic               waitrequest
);

  logic [region_w-1:0] region;      // region field of the live address
  logic [region_w-1:0] region_q;    // region seen while the sram stalls
  logic                stall_q;     // previous cycle was a wait state
  logic [region_w-1:0] region_sel;  // region that steers strobes and mux

  assign region     = address[addr_w-1 -: region_w];  // bits 31:16
  assign word_index = address[index_w+1:2];           // drop byte offset

  // keep the selection fixed across the sram wait state
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stall_q  <= 1'b0;
      region_q <= '0;
    end else begin
      stall_q <= sram_waitrequest;
      if (sram_waitrequest) begin
        region_q <= region;  // capture on the stalled cycle
      end
    end
  end

  assign region_sel = stall_q ? region_q : region;

  // per-slave strobes decoded only here from the region
  assign sram_read   = read  && (region_sel == region_sram);
  assign sram_write  = write && (region_sel == region_sram);
  assign irq_write   = write && (region_sel == region_irq);
  assign cache_write = write && (region_sel == region_cache);
  assign vga_write   = write && (region_sel == region_vga);
  assign hid_read    = read  && (region_sel == region_hid);

  // return path
  always_comb begin
    readdata    = '0;  // unmapped and write-only read as zero
    waitrequest = 1'b0;  // nobody but the sram stalls
    case (region_sel)
      region_sram: begin
        readdata    = sram_readdata;
        waitrequest = sram_waitrequest;
      end
      region_irq: readdata = irq_readdata;  // pending word
      region_hid: readdata = hid_readdata;  // zero unless arrived
      default: ;
    endcase
  end

endmodule

/* logic/ctrl_regs.sv */
`timescale 1ns/1ns

module ctrl_regs
  import sys_map_pkg::*;
  import sys_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   cache_write,
  input  logic                   vga_write,
  input  logic [index_w-1:0]     word_index,
  input  logic [data_w-1:0]      writedata,
  output logic                   flush_cache,
  output logic [page_w-1:0]      flush_page,
  output logic [vga_mode_w-1:0]  vga_mode,
  output logic [line_base_w-1:0] line_base,
  output logic                   block_vga
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      flush_cache <= 1'b0;
      flush_page  <= '0;
      vga_mode    <= vga_mode_reset;  // mode 3 out of reset
      line_base   <= '0;
      block_vga   <= 1'b0;
    end else begin
      // cache control with only index 0 live
      if (cache_write && word_index == index_w'(reg_cache_ctrl)) begin
        flush_cache <= writedata[flush_bit];
        flush_page  <= writedata[page_w-1:0];
      end
      // vga control
      if (vga_write) begin
        case (word_index)
          index_w'(reg_vga_mode):  vga_mode  <= writedata[vga_mode_w-1:0];
          index_w'(reg_vga_base):  line_base <= writedata[line_base_w-1:0];
          index_w'(reg_vga_block): block_vga <= writedata[0];
          default: ;  // other indices ignored
        endcase
      end
    end
  end

endmodule

/* logic/hid_rx.sv */
`timescale 1ns/1ns

module hid_rx
  import sys_map_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              hid_dat,
  input  logic              hid_clk,
  input  logic              hid_str,
  input  logic              read,
  output logic [data_w-1:0] readdata,
  output logic              hid_arrived
);

  logic [2:0]        clk_sync;  // sync pair plus edge stage
  logic [2:0]        str_sync;  // same for the strobe
  logic [1:0]        dat_sync;  // data in step with clk_sync[1]
  logic [data_w-1:0] shift_q;   // received word
  logic              arrived;   // word waiting for the cpu
  logic              clk_rise;
  logic              str_rise;

  assign clk_rise = clk_sync[1] && !clk_sync[2];
  assign str_rise = str_sync[1] && !str_sync[2];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      clk_sync    <= '0;
      str_sync    <= '0;
      arrived     <= 1'b0;
      hid_arrived <= 1'b0;
    end else begin
      clk_sync    <= {clk_sync[1:0], hid_clk};
      str_sync    <= {str_sync[1:0], hid_str};
      hid_arrived <= str_rise;  // one-cycle pulse to irq_ctrl
      if (read) begin
        arrived <= 1'b0;  // cpu took the word
      end
      if (str_rise) begin
        arrived <= 1'b1;  // new strobe beats a read
      end
    end
  end

  // newest bit enters at the top, word moves down
  always_ff @(posedge clk) begin
    dat_sync <= {dat_sync[0], hid_dat};
    if (clk_rise) begin
      shift_q <= {dat_sync[1], shift_q[data_w-1:1]};
    end
  end

  assign readdata = arrived ? shift_q : '0;

endmodule

/* logic/irq_ctrl.sv */
`timescale 1ns/1ns

module irq_ctrl
  import sys_map_pkg::*;
  import sys_regs_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  input  logic               write,
  input  logic [index_w-1:0] word_index,
  input  logic [data_w-1:0]  writedata,
  input  logic               timer_irq,
  input  logic               uart_irq,
  input  logic               hid_arrived,
  output logic [irq_w-1:0]   pending,
  output logic               irq_req,
  output logic               timer_ack,
  output logic               uart_ack
);

  logic [1:0]       timer_sync;  // 2-flop sync of timer_irq
  logic [1:0]       uart_sync;   // 2-flop sync of uart_irq
  logic             timer_req;
  logic             uart_req;
  logic [irq_w-1:0] set_mask;    // bits captured this cycle
  logic [irq_w-1:0] clr_mask;    // bits written as one

  assign timer_req = timer_sync[1];
  assign uart_req  = uart_sync[1];

  // a request is new while its ack is still low
  always_comb begin
    set_mask                = '0;
    set_mask[irq_timer_bit] = timer_req && !timer_ack;
    set_mask[irq_uart_bit]  = uart_req && !uart_ack;
    set_mask[irq_hid_bit]   = hid_arrived;  // already a clean pulse
  end

  assign clr_mask = (write && word_index == index_w'(reg_irq_pending)) ? writedata : '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      timer_sync <= '0;
      uart_sync  <= '0;
      timer_ack  <= 1'b0;
      uart_ack   <= 1'b0;
      pending    <= '0;
    end else begin
      timer_sync <= {timer_sync[0], timer_irq};
      uart_sync  <= {uart_sync[0], uart_irq};
      timer_ack  <= timer_req;  // rises with capture, drops after req
      uart_ack   <= uart_req;
      pending    <= (pending & ~clr_mask) | set_mask;  // set wins over clear
    end
  end

  assign irq_req = |pending;  // any source waiting

endmodule

/* logic/main_sram.sv */
`timescale 1ns/1ns

module main_sram
  import sys_map_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  input  logic               read,
  input  logic               write,
  input  logic [sram_aw-1:0] word_index,
  input  logic [be_w-1:0]    byteenable,
  input  logic [data_w-1:0]  writedata,
  output logic [data_w-1:0]  readdata,
  output logic               waitrequest
);

  logic [data_w-1:0] mem [sram_words];  // 512 x 32
  logic [data_w-1:0] rdata_q;             // registered read port
  logic              read_ack;            // second cycle of a read

  // byte-lane writes and a read port loaded on each read cycle
  always_ff @(posedge clk) begin
    if (write) begin
      for (int lane = 0; lane < be_w; lane++) begin
        if (byteenable[lane]) begin
          mem[word_index][lane*8 +: 8] <= writedata[lane*8 +: 8];  // this lane only
        end
      end
    end
    if (read) begin
      rdata_q <= mem[word_index];
    end
  end

  // one wait state per read even when reads come back to back
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else begin
      read_ack <= read && !read_ack;  // high for one cycle only
    end
  end

  assign waitrequest = read && !read_ack;
  assign readdata    = rdata_q;  // valid when read_ack is set

endmodule

/* logic/soc_fabric.sv */
`timescale 1ns/1ns

module soc_fabric
  import sys_map_pkg::*;
  import sys_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic [addr_w-1:0]      address,
  input  logic                   read,
  input  logic                   write,
  input  logic [data_w-1:0]      writedata,
  input  logic [be_w-1:0]        byteenable,
  output logic [data_w-1:0]      readdata,
  output logic                   waitrequest,
  input  logic                   timer_irq,
  input  logic                   uart_irq,
  output logic                   timer_ack,
  output logic                   uart_ack,
  output logic                   irq_req,
  input  logic                   hid_dat,
  input  logic                   hid_clk,
  input  logic                   hid_str,
  output logic                   flush_cache,
  output logic [page_w-1:0]      flush_page,
  output logic [vga_mode_w-1:0]  vga_mode,
  output logic [line_base_w-1:0] line_base,
  output logic                   block_vga
);

  logic [index_w-1:0] word_index;
  logic               sram_read;
  logic               sram_write;
  logic               irq_write;
  logic               cache_write;
  logic               vga_write;
  logic               hid_read;
  logic [data_w-1:0]  sram_readdata;
  logic               sram_waitrequest;
  logic [irq_w-1:0]   irq_pending;  // doubles as irq read data
  logic [data_w-1:0]  hid_readdata;
  logic               hid_arrived;  // hid_rx to irq_ctrl

  bus_decode u_bus_decode (
    .clk              (clk),
    .reset_n          (reset_n),
    .address          (address),
    .read             (read),
    .write            (write),
    .sram_readdata    (sram_readdata),
    .sram_waitrequest (sram_waitrequest),
    .irq_readdata     (irq_pending),
    .hid_readdata     (hid_readdata),
    .word_index       (word_index),
    .sram_read        (sram_read),
    .sram_write       (sram_write),
    .irq_write        (irq_write),
    .cache_write      (cache_write),
    .vga_write        (vga_write),
    .hid_read         (hid_read),
    .readdata         (readdata),
    .waitrequest      (waitrequest)
  );

  main_sram u_main_sram (
    .clk         (clk),
    .reset_n     (reset_n),
    .read        (sram_read),
    .write       (sram_write),
    .word_index  (word_index[sram_aw-1:0]),  // upper index bits alias
    .byteenable  (byteenable),
    .writedata   (writedata),
    .readdata    (sram_readdata),
    .waitrequest (sram_waitrequest)
  );

  irq_ctrl u_irq_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .write       (irq_write),
    .word_index  (word_index),
    .writedata   (writedata),
    .timer_irq   (timer_irq),
    .uart_irq    (uart_irq),
    .hid_arrived (hid_arrived),
    .pending     (irq_pending),
    .irq_req     (irq_req),
    .timer_ack   (timer_ack),
    .uart_ack    (uart_ack)
  );

  hid_rx u_hid_rx (
    .clk         (clk),
    .reset_n     (reset_n),
    .hid_dat     (hid_dat),
    .hid_clk     (hid_clk),
    .hid_str     (hid_str),
    .read        (hid_read),
    .readdata    (hid_readdata),
    .hid_arrived (hid_arrived)
  );

  ctrl_regs u_ctrl_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .cache_write (cache_write),
    .vga_write   (vga_write),
    .word_index  (word_index),
    .writedata   (writedata),
    .flush_cache (flush_cache),
    .flush_page  (flush_page),
    .vga_mode    (vga_mode),
    .line_base   (line_base),
    .block_vga   (block_vga)
  );

endmodule

/* logic/sys_map_pkg.sv */
package sys_map_pkg;

  localparam int addr_w   = 32;  // master address bus
  localparam int data_w   = 32;  // master data bus
  localparam int be_w     = 4;   // one enable per byte lane

  // address splits into region, word index and byte offset
  localparam int region_w = 16;  // top half selects the peripheral
  localparam int index_w  = 14;  // word index inside a region

  localparam logic [region_w-1:0] region_sram  = 16'h0200;  // main on-chip sram
  localparam logic [region_w-1:0] region_cache = 16'h0201;  // cache flush control
  localparam logic [region_w-1:0] region_irq   = 16'h0202;  // interrupt pending
  localparam logic [region_w-1:0] region_vga   = 16'h0206;  // vga control
  localparam logic [region_w-1:0] region_hid   = 16'h0207;  // serial hid receiver

  localparam int sram_words = 512;  // 2 KB
  localparam int sram_aw    = 9;    // log2 of sram_words

endpackage

/* logic/sys_regs_pkg.sv */
package sys_regs_pkg;

  // cache control region
  localparam int reg_cache_ctrl = 0;   // flush request and page
  localparam int flush_bit      = 31;  // flush enable
  localparam int page_w         = 15;  // page number in the low bits of the word

  // vga control region
  localparam int reg_vga_mode  = 0;  // display mode
  localparam int reg_vga_base  = 1;  // line base of the frame
  localparam int reg_vga_block = 2;  // blank the output
  localparam int vga_mode_w    = 2;
  localparam int line_base_w   = 16;

  localparam logic [vga_mode_w-1:0] vga_mode_reset = 2'd3;  // mode out of reset

  // interrupt controller
  localparam int reg_irq_pending = 0;   // read pending and write one to clear
  localparam int irq_timer_bit   = 0;
  localparam int irq_uart_bit    = 1;
  localparam int irq_hid_bit     = 2;
  localparam int irq_w           = 32;  // full pending word

endpackage

/* run.sh */
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ns -f tb.f --top-module tb_soc_fabric \
  -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb.f */
logic/sys_map_pkg.sv
logic/sys_regs_pkg.sv
logic/bus_decode.sv
logic/main_sram.sv
logic/irq_ctrl.sv
logic/hid_rx.sv
logic/ctrl_regs.sv
logic/soc_fabric.sv
bench/tb_soc_fabric.sv
